//--- hdl/exe_config.svh
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// Data path and address width
`define EXE_XLEN 32
`define EXE_SHAMT_W 5
`define EXE_BE_W (`EXE_XLEN/8)

`define EXE_RA_W 5

// Opcode field widths
`define EXE_ALU_OP_W 4
`define EXE_BR_OP_W 4
`define EXE_MUL_OP_W 2
`define EXE_MEM_OP_W 4
`define EXE_RES_SEL_W 3

`endif

//--- hdl/exe_pkg.sv
`include "exe_config.svh"

package exe_pkg;

	typedef enum logic [`EXE_ALU_OP_W-1:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
	} alu_op_e;

	typedef enum logic [`EXE_BR_OP_W-1:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
		BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
	} br_op_e;

	typedef enum logic [`EXE_MUL_OP_W-1:0] {
		MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU
	} mul_op_e;

	typedef enum logic [`EXE_MEM_OP_W-1:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU,
		MEM_LHU, MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	// Writeback source
	typedef enum logic [`EXE_RES_SEL_W-1:0] {
		RES_ALU, RES_LINK, RES_MUL, RES_LUI, RES_AUIPC, RES_LOAD
	} res_sel_e;

	typedef struct packed {
		logic [`EXE_XLEN-1:0] op_a;
		logic [`EXE_XLEN-1:0] op_b;
		logic [`EXE_XLEN-1:0] imm;	// B/J, I, S or U immediate
		logic [`EXE_XLEN-1:0] pc;
		logic [`EXE_RA_W-1:0] rd;
		logic                 we;
		res_sel_e             res_sel;
		alu_op_e              alu_op;
		br_op_e               br_op;
		mul_op_e              mul_op;
		mem_op_e              mem_op;
	} issue_pkt_t;

	typedef struct packed {
		logic [`EXE_RA_W-1:0] rd;
		logic                 we;
		logic [`EXE_XLEN-1:0] data;
		logic                 redirect;
		logic [`EXE_XLEN-1:0] target;	// Valid only with redirect
		logic                 misaligned;
	} wb_pkt_t;

	typedef struct packed {
		logic [`EXE_XLEN-1:0] addr;	// Word aligned
		logic [`EXE_XLEN-1:0] wdata;
		logic [`EXE_BE_W-1:0] be;
		logic                 write;
	} mem_req_t;

	// One memory word seen as byte lanes or half lanes
	typedef union packed {
		logic [`EXE_BE_W-1:0][7:0] b;
		logic [1:0][15:0]          h;
	} mem_word_u;

endpackage

//--- hdl/exe_alu.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_alu
	import exe_pkg::*;
(
	input  alu_op_e              alu_op,
	input  logic [`EXE_XLEN-1:0] a,
	input  logic [`EXE_XLEN-1:0] b,
	output logic [`EXE_XLEN-1:0] result
);

	logic [`EXE_SHAMT_W-1:0] shamt;

	assign shamt = b[`EXE_SHAMT_W-1:0];	// Low five bits only

	always_comb
	begin
		case (alu_op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_SLL:  result = a << shamt;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $signed(a) >>> shamt;	// Keeps the sign bit
			ALU_SLT:
			begin
				result = {{(`EXE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			end
			ALU_SLTU:
			begin
				result = {{(`EXE_XLEN-1){1'b0}}, a < b};
			end
			default:  result = '0;
		endcase
	end

endmodule

//--- hdl/exe_branch.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_branch
	import exe_pkg::*;
(
	input  br_op_e               br_op,
	input  logic [`EXE_XLEN-1:0] a,
	input  logic [`EXE_XLEN-1:0] b,
	input  logic [`EXE_XLEN-1:0] pc,
	input  logic [`EXE_XLEN-1:0] imm,
	output logic                 taken,
	output logic [`EXE_XLEN-1:0] target
);

	logic [`EXE_XLEN-1:0] jalr_sum;

	assign jalr_sum = a + imm;

	always_comb
	begin
		case (br_op)
			BR_BEQ:          taken = a == b;
			BR_BNE:          taken = a != b;
			BR_BLT:          taken = $signed(a) < $signed(b);
			BR_BGE:          taken = $signed(a) >= $signed(b);
			BR_BLTU:         taken = a < b;
			BR_BGEU:         taken = a >= b;
			BR_JAL, BR_JALR: taken = 1'b1;	// Jumps always redirect
			default:         taken = 1'b0;
		endcase
	end

	// Register-relative for JALR, low bit dropped
	assign target = (br_op == BR_JALR) ? {jalr_sum[`EXE_XLEN-1:1], 1'b0} : pc + imm;

endmodule

//--- hdl/exe_mul.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_mul
	import exe_pkg::*;
(
	input  mul_op_e              mul_op,
	input  logic [`EXE_XLEN-1:0] a,
	input  logic [`EXE_XLEN-1:0] b,
	output logic [`EXE_XLEN-1:0] result
);

	logic                          a_signed;
	logic                          b_signed;
	logic signed [`EXE_XLEN:0]     a_ext;
	logic signed [`EXE_XLEN:0]     b_ext;
	logic signed [2*`EXE_XLEN+1:0] prod;

	// MULHSU treats only rs1 as signed
	assign a_signed = (mul_op == MUL_MULH) || (mul_op == MUL_MULHSU);
	assign b_signed = mul_op == MUL_MULH;

	// One extra bit so a single signed multiply covers all three cases
	assign a_ext = {a_signed & a[`EXE_XLEN-1], a};
	assign b_ext = {b_signed & b[`EXE_XLEN-1], b};

	assign prod = a_ext * b_ext;

	always_comb
	begin
		if (mul_op == MUL_MUL)
		begin
			result = prod[`EXE_XLEN-1:0];	// Low half is sign-agnostic
		end
		else
		begin
			result = prod[2*`EXE_XLEN-1:`EXE_XLEN];
		end
	end

endmodule

//--- hdl/exe_lsu.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_lsu
	import exe_pkg::*;
(
	input  logic                 clk,
	input  logic                 nrst,
	input  mem_op_e              mem_op,
	input  logic [`EXE_XLEN-1:0] base,
	input  logic [`EXE_XLEN-1:0] offset,
	input  logic [`EXE_XLEN-1:0] store_data,
	output mem_req_t             req,
	output logic                 misaligned,
	input  logic [`EXE_XLEN-1:0] rsp_data,
	output logic [`EXE_XLEN-1:0] load_data
);

	logic [`EXE_XLEN-1:0] addr;
	logic                 is_load;
	logic                 is_store;
	mem_word_u            st_word;
	mem_word_u            rsp_word;
	logic [`EXE_BE_W-1:0] be;
	logic [1:0]           off_q;	// Lane of the outstanding load
	mem_op_e              op_q;
	logic [7:0]           rsp_byte;
	logic [15:0]          rsp_half;

	assign addr     = base + offset;
	assign is_load  = mem_op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
	assign is_store = mem_op inside {MEM_SB, MEM_SH, MEM_SW};

	always_comb
	begin
		case (mem_op)
			MEM_LH, MEM_LHU, MEM_SH: misaligned = addr[0];
			MEM_LW, MEM_SW:          misaligned = addr[1:0] != 2'b00;
			default:                 misaligned = 1'b0;
		endcase
	end

	// Replicate store data into every lane, enables pick the real one
	always_comb
	begin
		st_word.b = store_data;
		be        = '0;
		case (mem_op)
			MEM_SB:
			begin
				st_word.b = {`EXE_BE_W{store_data[7:0]}};
				be        = 4'b0001 << addr[1:0];
			end
			MEM_SH:
			begin
				st_word.h = {2{store_data[15:0]}};
				be        = addr[1] ? 4'b1100 : 4'b0011;
			end
			MEM_SW:  be = 4'b1111;
			default: be = '0;
		endcase
	end

	assign req.addr  = {addr[`EXE_XLEN-1:2], 2'b00};
	assign req.wdata = st_word;
	assign req.be    = be;
	assign req.write = is_store;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			off_q <= '0;
			op_q  <= MEM_NONE;
		end
		else if (is_load)
		begin
			off_q <= addr[1:0];
			op_q  <= mem_op;
		end
	end

	assign rsp_word.b = rsp_data;
	assign rsp_byte   = rsp_word.b[off_q];
	assign rsp_half   = rsp_word.h[off_q[1]];

	always_comb
	begin
		case (op_q)
			MEM_LB:  load_data = {{(`EXE_XLEN-8){rsp_byte[7]}}, rsp_byte};
			MEM_LBU: load_data = {{(`EXE_XLEN-8){1'b0}}, rsp_byte};
			MEM_LH:  load_data = {{(`EXE_XLEN-16){rsp_half[15]}}, rsp_half};
			MEM_LHU: load_data = {{(`EXE_XLEN-16){1'b0}}, rsp_half};
			default: load_data = rsp_data;	// LW
		endcase
	end

	a_store_be: assert property (@(posedge clk) disable iff (!nrst)
		is_store |-> req.be != '0);

endmodule

//--- hdl/exe_ctrl.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_ctrl
	import exe_pkg::*;
(
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  issue_pkt_t           in_pkt,
	output issue_pkt_t           ex_pkt,
	input  logic [`EXE_XLEN-1:0] alu_res,
	input  logic [`EXE_XLEN-1:0] mul_res,
	input  logic                 br_taken,
	input  logic [`EXE_XLEN-1:0] br_target,
	input  logic                 lsu_misaligned,
	input  logic [`EXE_XLEN-1:0] load_data,
	output logic                 mem_req_valid,
	input  logic                 mem_req_ready,
	input  logic                 mem_rsp_valid,
	output logic                 wb_valid,
	input  logic                 wb_ready,
	output wb_pkt_t              wb_pkt
);

	logic                 started;	// Holds off issue for one cycle out of reset
	logic                 s5_valid;
	logic                 load_wait;
	logic                 mem_done;	// Access finished but stage 6 was busy
	logic [`EXE_XLEN-1:0] load_buf;
	logic                 is_mem;
	logic                 is_store;
	logic                 req_fire;
	logic                 rsp_take;
	logic                 s5_done;
	logic                 s5_adv;
	logic                 s6_free;
	wb_pkt_t              wb_next;

	assign is_mem   = ex_pkt.mem_op != MEM_NONE;
	assign is_store = ex_pkt.mem_op inside {MEM_SB, MEM_SH, MEM_SW};

	assign mem_req_valid = s5_valid & is_mem & ~lsu_misaligned & ~load_wait & ~mem_done;
	assign req_fire      = mem_req_valid & mem_req_ready;
	assign rsp_take      = load_wait & mem_rsp_valid;

	// Stores are posted, so the request transfer completes them
	assign s5_done  = ~is_mem | lsu_misaligned | mem_done | (req_fire & is_store) | rsp_take;
	assign s6_free  = ~wb_valid | wb_ready;
	assign s5_adv   = s5_valid & s5_done & s6_free;
	assign in_ready = started & (~s5_valid | s5_adv);

	always_comb
	begin
		wb_next.rd         = ex_pkt.rd;
		wb_next.we         = ex_pkt.we & ~lsu_misaligned;
		wb_next.redirect   = br_taken;
		wb_next.target     = br_target;
		wb_next.misaligned = lsu_misaligned;
		case (ex_pkt.res_sel)
			RES_ALU:   wb_next.data = alu_res;
			RES_LINK:  wb_next.data = ex_pkt.pc + 32'd4;
			RES_MUL:   wb_next.data = mul_res;
			RES_LUI:   wb_next.data = ex_pkt.imm;
			RES_AUIPC: wb_next.data = ex_pkt.pc + ex_pkt.imm;
			RES_LOAD:  wb_next.data = mem_done ? load_buf : load_data;
			default:   wb_next.data = '0;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			started   <= 1'b0;
			s5_valid  <= 1'b0;
			load_wait <= 1'b0;
			mem_done  <= 1'b0;
			wb_valid  <= 1'b0;
		end
		else
		begin
			started <= 1'b1;
			if (in_ready)
				s5_valid <= in_valid;
			if (req_fire && !is_store)
				load_wait <= 1'b1;
			else if (rsp_take)
				load_wait <= 1'b0;
			if (s5_adv)
				mem_done <= 1'b0;
			else if ((req_fire && is_store) || rsp_take)
				mem_done <= 1'b1;
			if (s5_adv)
				wb_valid <= 1'b1;
			else if (wb_ready)
				wb_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			ex_pkt <= in_pkt;
		if (rsp_take)
			load_buf <= load_data;	// Response has no ready, keep it here
		if (s5_adv)
			wb_pkt <= wb_next;
	end

	a_wb_hold: assert property (@(posedge clk) disable iff (!nrst)
		wb_valid && !wb_ready |=> wb_valid && $stable(wb_pkt));

	// Request stays up until the memory takes it
	a_req_hold: assert property (@(posedge clk) disable iff (!nrst)
		mem_req_valid && !mem_req_ready |=> mem_req_valid);

	a_rsp_expected: assert property (@(posedge clk) disable iff (!nrst)
		mem_rsp_valid |-> load_wait);

endmodule

//--- hdl/exe_stage.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_stage
	import exe_pkg::*;
(
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  issue_pkt_t           in_pkt,
	output logic                 wb_valid,
	input  logic                 wb_ready,
	output wb_pkt_t              wb_pkt,
	output logic                 mem_req_valid,
	input  logic                 mem_req_ready,
	output mem_req_t             mem_req,
	input  logic                 mem_rsp_valid,
	input  logic [`EXE_XLEN-1:0] mem_rsp_data
);

	issue_pkt_t           ex_pkt;	// Stage 5 contents
	logic [`EXE_XLEN-1:0] alu_res;
	logic [`EXE_XLEN-1:0] mul_res;
	logic                 br_taken;
	logic [`EXE_XLEN-1:0] br_target;
	logic                 lsu_misaligned;
	logic [`EXE_XLEN-1:0] load_data;

	exe_ctrl i_ctrl (
		.clk            (clk),
		.nrst           (nrst),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_pkt         (in_pkt),
		.ex_pkt         (ex_pkt),
		.alu_res        (alu_res),
		.mul_res        (mul_res),
		.br_taken       (br_taken),
		.br_target      (br_target),
		.lsu_misaligned (lsu_misaligned),
		.load_data      (load_data),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_rsp_valid  (mem_rsp_valid),
		.wb_valid       (wb_valid),
		.wb_ready       (wb_ready),
		.wb_pkt         (wb_pkt)
	);

	exe_alu i_alu (
		.alu_op (ex_pkt.alu_op),
		.a      (ex_pkt.op_a),
		.b      (ex_pkt.op_b),
		.result (alu_res)
	);

	exe_branch i_branch (
		.br_op  (ex_pkt.br_op),
		.a      (ex_pkt.op_a),
		.b      (ex_pkt.op_b),
		.pc     (ex_pkt.pc),
		.imm    (ex_pkt.imm),
		.taken  (br_taken),
		.target (br_target)
	);

	exe_mul i_mul (
		.mul_op (ex_pkt.mul_op),
		.a      (ex_pkt.op_a),
		.b      (ex_pkt.op_b),
		.result (mul_res)
	);

	// Base from rs1, offset from the immediate, store data from rs2
	exe_lsu i_lsu (
		.clk        (clk),
		.nrst       (nrst),
		.mem_op     (ex_pkt.mem_op),
		.base       (ex_pkt.op_a),
		.offset     (ex_pkt.imm),
		.store_data (ex_pkt.op_b),
		.req        (mem_req),
		.misaligned (lsu_misaligned),
		.rsp_data   (mem_rsp_data),
		.load_data  (load_data)
	);

endmodule

//--- verif/exe_mem_model.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_mem_model
	import exe_pkg::*;
(
	input  logic                 clk,
	input  logic                 nrst,
	input  logic [1:0]           delay,	// Response delay for the next read
	input  logic                 req_valid,
	output logic                 req_ready,
	input  mem_req_t             req,
	output logic                 rsp_valid,
	output logic [`EXE_XLEN-1:0] rsp_data
);

	logic [`EXE_XLEN-1:0] mem [16];
	logic [`EXE_XLEN-1:0] wmask;
	logic [`EXE_XLEN-1:0] rd_word;
	logic                 busy;
	logic [1:0]           wait_cnt;
	logic [4:0]           idx;

	assign req_ready = !busy;	// One read outstanding at most
	assign wmask = {{8{req.be[3]}}, {8{req.be[2]}}, {8{req.be[1]}}, {8{req.be[0]}}};

	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			// Word i holds 0x01020304 times (i+1)
			for (idx = 5'd0; idx < 5'd16; idx = idx + 5'd1)
				mem[idx[3:0]] <= 32'h01020304 * (idx + 5'd1);
			busy      <= 1'b0;
			wait_cnt  <= 2'd0;
			rd_word   <= '0;
			rsp_valid <= 1'b0;
			rsp_data  <= '0;
		end
		else
		begin
			rsp_valid <= 1'b0;
			if (busy)
			begin
				if (wait_cnt == 2'd0)
				begin
					rsp_valid <= 1'b1;
					rsp_data  <= rd_word;
					busy      <= 1'b0;
				end
				else
					wait_cnt <= wait_cnt - 2'd1;
			end
			else if (req_valid)
			begin
				if (req.write)	// Posted, no response
					mem[req.addr[5:2]] <= (mem[req.addr[5:2]] & ~wmask) | (req.wdata & wmask);
				else
				begin
					busy     <= 1'b1;
					wait_cnt <= delay;
					rd_word  <= mem[req.addr[5:2]];
				end
			end
		end
	end

endmodule

//--- verif/exe_tb.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_tb
	import exe_pkg::*;
();

	logic                 clk;
	logic                 nrst;
	logic                 in_valid;
	logic                 in_ready;
	issue_pkt_t           in_pkt;
	logic                 wb_valid;
	logic                 wb_ready;
	wb_pkt_t              wb_pkt;
	logic                 mem_req_valid;
	logic                 mem_req_ready;
	mem_req_t             mem_req;
	logic                 mem_rsp_valid;
	logic [`EXE_XLEN-1:0] mem_rsp_data;
	logic [1:0]           mem_delay;

	issue_pkt_t  pkts[$];	// Stimulus column
	wb_pkt_t     exps[$];	// Expected writeback column
	int          out_count = 0;
	int          req_count = 0;
	logic [31:0] lfsr = 32'h483075aa;

	exe_stage i_dut (
		.clk           (clk),
		.nrst          (nrst),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_pkt        (in_pkt),
		.wb_valid      (wb_valid),
		.wb_ready      (wb_ready),
		.wb_pkt        (wb_pkt),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req       (mem_req),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_data  (mem_rsp_data)
	);

	exe_mem_model i_mem (
		.clk       (clk),
		.nrst      (nrst),
		.delay     (mem_delay),
		.req_valid (mem_req_valid),
		.req_ready (mem_req_ready),
		.req       (mem_req),
		.rsp_valid (mem_rsp_valid),
		.rsp_data  (mem_rsp_data)
	);

	// Right-shift Galois form of x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          k;
		r = '0;
		for (k = 0; k < n; k++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	function automatic issue_pkt_t blank_pkt(input logic [4:0] rd, input res_sel_e sel);
		issue_pkt_t p;
		p = '0;
		p.rd = rd;
		p.we = rd != 5'd0;
		p.res_sel = sel;
		return p;
	endfunction

	function automatic issue_pkt_t alu_pkt(input alu_op_e op, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] rd);
		issue_pkt_t p;
		p = blank_pkt(rd, RES_ALU);
		p.alu_op = op;
		p.op_a = a;
		p.op_b = b;
		return p;
	endfunction

	function automatic issue_pkt_t br_pkt(input br_op_e op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] pc, input logic [31:0] imm,
		input logic [4:0] rd);
		issue_pkt_t p;
		p = blank_pkt(rd, RES_LINK);	// Link value only lands when rd is set
		p.br_op = op;
		p.op_a = a;
		p.op_b = b;
		p.pc = pc;
		p.imm = imm;
		return p;
	endfunction

	function automatic issue_pkt_t mul_pkt(input mul_op_e op, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] rd);
		issue_pkt_t p;
		p = blank_pkt(rd, RES_MUL);
		p.mul_op = op;
		p.op_a = a;
		p.op_b = b;
		return p;
	endfunction

	function automatic issue_pkt_t upper_pkt(input res_sel_e sel, input logic [31:0] pc,
		input logic [31:0] imm, input logic [4:0] rd);
		issue_pkt_t p;
		p = blank_pkt(rd, sel);
		p.pc = pc;
		p.imm = imm;
		return p;
	endfunction

	function automatic issue_pkt_t mem_pkt(input mem_op_e op, input logic [31:0] base,
		input logic [31:0] imm, input logic [31:0] sdata, input logic [4:0] rd);
		issue_pkt_t p;
		p = blank_pkt(rd, RES_LOAD);
		p.mem_op = op;
		p.op_a = base;
		p.imm = imm;
		p.op_b = sdata;
		return p;
	endfunction

	task automatic push_entry(input issue_pkt_t p, input logic we, input logic [31:0] data,
		input logic redirect, input logic [31:0] target, input logic mis);
		wb_pkt_t e;
		e.rd = p.rd;
		e.we = we;
		e.data = data;
		e.redirect = redirect;
		e.target = target;
		e.misaligned = mis;
		pkts.push_back(p);
		exps.push_back(e);
	endtask

	task automatic result_entry(input issue_pkt_t p, input logic [31:0] data);
		push_entry(p, 1'b1, data, 1'b0, 32'd0, 1'b0);
	endtask

	task automatic quiet_entry(input issue_pkt_t p);
		push_entry(p, 1'b0, 32'd0, 1'b0, 32'd0, 1'b0);
	endtask

	task automatic jump_entry(input issue_pkt_t p, input logic [31:0] data,
		input logic [31:0] target);
		push_entry(p, p.we, data, 1'b1, target, 1'b0);
	endtask

	task automatic fault_entry(input issue_pkt_t p);
		push_entry(p, 1'b0, 32'd0, 1'b0, 32'd0, 1'b1);
	endtask

	task automatic build_table();
		result_entry(alu_pkt(ALU_ADD, 32'd5, 32'd7, 5'd1), 32'd12);
		result_entry(alu_pkt(ALU_SUB, 32'd3, 32'd5, 5'd2), 32'hfffffffe);
		result_entry(alu_pkt(ALU_AND, 32'hf0f0f0f0, 32'h0ff00ff0, 5'd3), 32'h00f000f0);
		result_entry(alu_pkt(ALU_OR, 32'hf0f0f0f0, 32'h0ff00ff0, 5'd4), 32'hfff0fff0);
		result_entry(alu_pkt(ALU_XOR, 32'h12345678, 32'hffff0000, 5'd5), 32'hedcb5678);
		result_entry(alu_pkt(ALU_SLL, 32'd1, 32'h24, 5'd6), 32'h10);	// Shift by 4 only
		result_entry(alu_pkt(ALU_SRL, 32'h80000000, 32'd4, 5'd7), 32'h08000000);
		result_entry(alu_pkt(ALU_SRA, 32'h80000000, 32'd4, 5'd8), 32'hf8000000);
		result_entry(alu_pkt(ALU_SLT, 32'hffffffff, 32'd1, 5'd9), 32'd1);
		result_entry(alu_pkt(ALU_SLTU, 32'hffffffff, 32'd1, 5'd10), 32'd0);
		jump_entry(br_pkt(BR_BEQ, 32'd5, 32'd5, 32'h100, 32'h20, 5'd0), 32'd0, 32'h120);
		quiet_entry(br_pkt(BR_BNE, 32'd5, 32'd5, 32'h100, 32'h20, 5'd0));
		jump_entry(br_pkt(BR_BLT, 32'hffffffff, 32'd1, 32'h100, 32'h20, 5'd0), 32'd0, 32'h120);
		quiet_entry(br_pkt(BR_BGE, 32'hffffffff, 32'd1, 32'h100, 32'h20, 5'd0));
		jump_entry(br_pkt(BR_BGEU, 32'hffffffff, 32'd1, 32'h100, 32'hfffffff0, 5'd0),
			32'd0, 32'hf0);	// Backward target
		jump_entry(br_pkt(BR_JAL, 32'd0, 32'd0, 32'h200, 32'h40, 5'd1), 32'h204, 32'h240);
		jump_entry(br_pkt(BR_JALR, 32'h1001, 32'd0, 32'h300, 32'h10, 5'd2), 32'h304, 32'h1010);
		// 7 * -3 = -21
		result_entry(mul_pkt(MUL_MUL, 32'd7, 32'hfffffffd, 5'd11), 32'hffffffeb);
		// 2^62, high word 0x40000000
		result_entry(mul_pkt(MUL_MULH, 32'h80000000, 32'h80000000, 5'd12), 32'h40000000);
		// -1 * (2^32-1) = 0xffffffff_00000001
		result_entry(mul_pkt(MUL_MULHSU, 32'hffffffff, 32'hffffffff, 5'd13), 32'hffffffff);
		// (2^32-1)^2 = 0xfffffffe_00000001
		result_entry(mul_pkt(MUL_MULHU, 32'hffffffff, 32'hffffffff, 5'd14), 32'hfffffffe);
		result_entry(upper_pkt(RES_LUI, 32'h400, 32'h12345000, 5'd15), 32'h12345000);
		result_entry(upper_pkt(RES_AUIPC, 32'h400, 32'h00001000, 5'd16), 32'h00001400);
		// Word 9 at 0x24 rewritten piece by piece
		quiet_entry(mem_pkt(MEM_SW, 32'h20, 32'h4, 32'h89abcdef, 5'd0));
		result_entry(mem_pkt(MEM_LW, 32'h20, 32'h4, 32'd0, 5'd17), 32'h89abcdef);
		quiet_entry(mem_pkt(MEM_SB, 32'h24, 32'h1, 32'h000000c3, 5'd0));
		result_entry(mem_pkt(MEM_LB, 32'h24, 32'h1, 32'd0, 5'd18), 32'hffffffc3);
		result_entry(mem_pkt(MEM_LBU, 32'h24, 32'h1, 32'd0, 5'd19), 32'h000000c3);
		quiet_entry(mem_pkt(MEM_SH, 32'h20, 32'h6, 32'h00007e5a, 5'd0));
		result_entry(mem_pkt(MEM_LH, 32'h20, 32'h6, 32'd0, 5'd20), 32'h00007e5a);
		result_entry(mem_pkt(MEM_LHU, 32'h20, 32'h4, 32'd0, 5'd21), 32'h0000c3ef);
		result_entry(mem_pkt(MEM_LH, 32'h20, 32'h4, 32'd0, 5'd22), 32'hffffc3ef);
		result_entry(mem_pkt(MEM_LW, 32'h24, 32'h0, 32'd0, 5'd23), 32'h7e5ac3ef);
		result_entry(mem_pkt(MEM_LW, 32'h0, 32'h8, 32'd0, 5'd25), 32'h0306090c);	// Preload
		fault_entry(mem_pkt(MEM_LH, 32'h20, 32'h1, 32'd0, 5'd26));
		fault_entry(mem_pkt(MEM_SW, 32'h20, 32'h2, 32'h55aa55aa, 5'd0));
		// Word 8 still holds its preload value
		result_entry(mem_pkt(MEM_LW, 32'h20, 32'h0, 32'd0, 5'd27), 32'h09121b24);
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("Fail %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		int exp_reqs;
		nrst = 1'b0;
		in_valid = 1'b0;
		in_pkt = '0;
		build_table();
		exp_reqs = 0;
		foreach (pkts[i])
			if (pkts[i].mem_op != MEM_NONE && !exps[i].misaligned)
				exp_reqs++;
		repeat (8) @(posedge clk);
		// Handshake outputs idle in reset
		check(32'(in_ready), 32'd0, "in_ready in reset");
		check(32'(wb_valid), 32'd0, "wb_valid in reset");
		check(32'(mem_req_valid), 32'd0, "mem_req_valid in reset");
		#2;
		nrst = 1'b1;
		foreach (pkts[i])
		begin
			in_pkt = pkts[i];
			in_valid = 1'b1;
			@(negedge clk);
			while (!in_ready)
				@(negedge clk);
			@(posedge clk);	// Accepted here
			#2;
		end
		in_valid = 1'b0;
		in_pkt = '0;
		wait (out_count == pkts.size());
		repeat (20) @(posedge clk);	// Room for a stray extra writeback
		check(32'(req_count), 32'(exp_reqs), "memory request count");
		$display("All tests passed");
		$finish;
	end

	// Writeback back-pressure in random stretches, memory latency per cycle
	initial
	begin
		int   hold;
		logic level;
		wb_ready = 1'b0;
		mem_delay = 2'd0;
		hold = 0;
		level = 1'b0;
		forever
		begin
			@(posedge clk);
			#2;
			mem_delay = 2'(rand_bits(2));
			if (hold == 0)
			begin
				level = rand_bits(1) != 0;
				hold = int'(rand_bits(2)) + 1;
			end
			wb_ready = level;
			hold = hold - 1;
		end
	end

	initial
	begin
		wb_pkt_t e;
		forever
		begin
			@(negedge clk);
			if (nrst && mem_req_valid && mem_req_ready)
				req_count++;
			if (nrst && wb_valid && wb_ready)
			begin
				check(32'(out_count < pkts.size()), 32'd1, "writeback beyond the last entry");
				e = exps[out_count];
				check(32'(wb_pkt.rd), 32'(e.rd), $sformatf("entry %0d rd", out_count));
				check(32'(wb_pkt.we), 32'(e.we), $sformatf("entry %0d we", out_count));
				check(32'(wb_pkt.misaligned), 32'(e.misaligned),
					$sformatf("entry %0d misaligned", out_count));
				check(32'(wb_pkt.redirect), 32'(e.redirect),
					$sformatf("entry %0d redirect", out_count));
				if (e.we)
					check(wb_pkt.data, e.data, $sformatf("entry %0d data", out_count));
				if (e.redirect)
					check(wb_pkt.target, e.target, $sformatf("entry %0d target", out_count));
				out_count++;
			end
		end
	end

	initial
	begin
		int limit;
		#1;	// Table is built at time zero
		limit = pkts.size() * 40 + 8 + 20;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Some tests failed");
		$fatal(1, "Timeout");
	end

endmodule

//--- exe_stage.f
+incdir+hdl
hdl/exe_pkg.sv
hdl/exe_alu.sv
hdl/exe_branch.sv
hdl/exe_mul.sv
hdl/exe_lsu.sv
hdl/exe_ctrl.sv
hdl/exe_stage.sv
verif/exe_mem_model.sv
verif/exe_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module exe_tb -f exe_stage.f; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/Vexe_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
	exit 0
fi

echo "Pass line not found in simulation output"
exit 1
